// File: hw/divPkg.sv
// Shared widths, queue sizing and FSM codes for the divide unit; import with divPkg::*
package divPkg;

	// ============================================================
	// Datapath sizing
	// ============================================================

	// Operand and result width of the integer divide
	localparam int unsigned divWidth = 64;

	// The core iterates divWidth+1 times, so the counter must hold that value
	localparam int unsigned divCountWidth = $clog2(divWidth + 2);

	// ============================================================
	// Request queue sizing
	// ============================================================

	// Number of prepared requests that can wait in front of the core
	localparam int unsigned divQueueDepth = 4;

	// Read and write pointer width, the depth is a power of two so pointers wrap freely
	localparam int unsigned divQueuePtrWidth = $clog2(divQueueDepth);

	// ============================================================
	// Divider FSM encoding
	// ============================================================

	// Waiting for a request at the queue head
	localparam logic [1:0] divStIdle = 2'd0;

	// Shift-subtract iterations are running
	localparam logic [1:0] divStDivide = 2'd1;

	// Signs are applied and the result is registered
	localparam logic [1:0] divStResult = 2'd2;

endpackage

// File: hw/divReqIf.sv
// One prepared divide request, passed from operand prep to the queue and from the queue to the core
`timescale 1ns/100ps

interface divReqIf
	import divPkg::*;
	();

	// Strobe on the prep side, non-empty level on the queue head side
	logic valid;

	// Unsigned magnitudes that the core divides
	logic [divWidth-1:0] dividendMag;
	logic [divWidth-1:0] divisorMag;

	// Two's-complement negation to apply on the way out
	logic negQuot;
	logic negRem;

	// The selected divisor was zero
	logic zeroDiv;

	// The side that produces a request
	modport src (
		output valid,
		output dividendMag,
		output divisorMag,
		output negQuot,
		output negRem,
		output zeroDiv
	);

	// The side that consumes a request
	modport dst (
		input valid,
		input dividendMag,
		input divisorMag,
		input negQuot,
		input negRem,
		input zeroDiv
	);

endinterface

// File: hw/divOperandPrep.sv
// Combinational operand preparation that turns a raw divide issue into a queue request
`timescale 1ns/100ps

module divOperandPrep
	import divPkg::*;
	(
	input  logic                issue,
	input  logic                ss,
	input  logic                su,
	input  logic                isDivi,
	input  logic [divWidth-1:0] a,
	input  logic [divWidth-1:0] b,
	input  logic [divWidth-1:0] imm,
	divReqIf.src                req
);

	// Divisor picked from the immediate or the second register operand
	logic [divWidth-1:0] divisorSel;

	// Sign bits of the two operands as two's-complement values
	logic dividendNeg;
	logic divisorNeg;

	// Absolute values, only used in the signed modes
	logic [divWidth-1:0] dividendAbs;
	logic [divWidth-1:0] divisorAbs;

	// ============================================================
	// Operand selection and magnitudes
	// ============================================================

	assign divisorSel = isDivi ? imm : b;

	assign dividendNeg = a[divWidth-1];
	assign divisorNeg  = divisorSel[divWidth-1];

	// Negating the most negative value wraps to itself, which is still the right
	// unsigned magnitude
	assign dividendAbs = dividendNeg ? -a : a;
	assign divisorAbs  = divisorNeg ? -divisorSel : divisorSel;

	// ============================================================
	// Request fields per mode
	// ============================================================

	always_comb begin
		if (ss) begin
			// Fully signed, quotient sign follows the operand signs and the
			// remainder takes the dividend sign
			req.dividendMag = dividendAbs;
			req.divisorMag  = divisorAbs;
			req.negQuot     = dividendNeg ^ divisorNeg;
			req.negRem      = dividendNeg;
		end else if (su) begin
			// Signed dividend over unsigned divisor, both results follow the dividend
			req.dividendMag = dividendAbs;
			req.divisorMag  = divisorSel;
			req.negQuot     = dividendNeg;
			req.negRem      = dividendNeg;
		end else begin
			// Plain unsigned divide
			req.dividendMag = a;
			req.divisorMag  = divisorSel;
			req.negQuot     = 1'b0;
			req.negRem      = 1'b0;
		end
	end

	// A zero divisor still runs through the core and is flagged at the end
	assign req.zeroDiv = (divisorSel == '0);

	// No state here, so the write strobe is the issue itself
	assign req.valid = issue;

endmodule

// File: hw/divReqQueue.sv
// Small circular queue of prepared divide requests between operand prep and the divider core
`timescale 1ns/100ps

module divReqQueue
	import divPkg::*;
	(
	input  logic clk,
	input  logic rst,
	input  logic flush,
	divReqIf.dst inReq,
	divReqIf.src outReq,
	input  logic pop,
	output logic full
);

	// Entry storage, one array per request field
	logic [divWidth-1:0] dividendMem [divQueueDepth];
	logic [divWidth-1:0] divisorMem  [divQueueDepth];
	logic                negQuotMem  [divQueueDepth];
	logic                negRemMem   [divQueueDepth];
	logic                zeroDivMem  [divQueueDepth];

	// Pointers wrap naturally because the depth is a power of two
	logic [divQueuePtrWidth-1:0] wrPtr;
	logic [divQueuePtrWidth-1:0] rdPtr;

	// Occupancy needs one extra bit to count up to the full depth
	logic [divQueuePtrWidth:0] count;

	logic wrEn;
	logic rdEn;

	// ============================================================
	// Enables
	// ============================================================

	// Writes while full are dropped, and a flush discards a same-cycle issue
	assign wrEn = inReq.valid && !full && !flush;
	assign rdEn = pop && outReq.valid && !flush;

	assign full = (count == (divQueuePtrWidth + 1)'(divQueueDepth));

	// ============================================================
	// Storage
	// ============================================================

	always_ff @(posedge clk) begin
		if (wrEn) begin
			dividendMem[wrPtr] <= inReq.dividendMag;
			divisorMem[wrPtr]  <= inReq.divisorMag;
			negQuotMem[wrPtr]  <= inReq.negQuot;
			negRemMem[wrPtr]   <= inReq.negRem;
			zeroDivMem[wrPtr]  <= inReq.zeroDiv;
		end
	end

	// ============================================================
	// Pointers and occupancy
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			// Simultaneous write and read leave the count unchanged
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry is shown as long as anything is queued
	assign outReq.valid       = (count != '0);
	assign outReq.dividendMag = dividendMem[rdPtr];
	assign outReq.divisorMag  = divisorMem[rdPtr];
	assign outReq.negQuot     = negQuotMem[rdPtr];
	assign outReq.negRem      = negRemMem[rdPtr];
	assign outReq.zeroDiv     = zeroDivMem[rdPtr];

endmodule

// File: hw/divRestoringCore.sv
// Restoring shift-subtract divider that takes requests from the queue head, one bit per clock
`timescale 1ns/100ps

module divRestoringCore
	import divPkg::*;
	(
	input  logic                clk,
	input  logic                rst,
	input  logic                abort,
	divReqIf.dst                req,
	output logic                pop,
	output logic                busy,
	output logic                resultValid,
	output logic [divWidth-1:0] quot,
	output logic [divWidth-1:0] rem,
	output logic                dvByZr
);

	logic [1:0]               state;
	logic [divCountWidth-1:0] cnt;

	// Partial remainder carries one extra bit so the shifted value fits before the compare
	logic [divWidth:0]   remReg;
	logic [divWidth-1:0] quotReg;
	logic [divWidth-1:0] divisorReg;

	// Result adjustments captured with the request
	logic negQuotReg;
	logic negRemReg;
	logic zeroDivReg;

	// One restoring step
	logic                canSub;
	logic [divWidth-1:0] remDiff;
	logic [divWidth-1:0] remNext;

	// ============================================================
	// Handshake with the queue
	// ============================================================

	// Take the head as soon as the core is free, unless the work is being thrown away
	assign pop  = (state == divStIdle) && req.valid && !abort;
	assign busy = (state == divStDivide) || (state == divStResult);

	// ============================================================
	// Restoring step
	// ============================================================

	// A zero divisor always subtracts, which fills the quotient with ones and
	// leaves the dividend in the remainder
	assign canSub  = (remReg >= {1'b0, divisorReg});
	// The true difference is below the divisor, so the low bits are exact
	assign remDiff = remReg[divWidth-1:0] - divisorReg;
	assign remNext = canSub ? remDiff : remReg[divWidth-1:0];

	// ============================================================
	// Control FSM
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= divStIdle;
			cnt         <= '0;
			resultValid <= 1'b0;
			dvByZr      <= 1'b0;
		end else if (abort) begin
			// Drop the running divide without producing a result
			state       <= divStIdle;
			cnt         <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= 1'b0;
			case (state)
				divStIdle: begin
					if (pop) begin
						cnt   <= divCountWidth'(divWidth + 1);
						state <= divStDivide;
					end
				end
				divStDivide: begin
					cnt <= cnt - 1'b1;
					// Last of the divWidth+1 steps
					if (cnt == divCountWidth'(1))
						state <= divStResult;
				end
				divStResult: begin
					resultValid <= 1'b1;
					dvByZr      <= zeroDivReg;
					state       <= divStIdle;
				end
				default: state <= divStIdle;
			endcase
		end
	end

	// ============================================================
	// Datapath
	// ============================================================

	always_ff @(posedge clk) begin
		if (pop) begin
			// The dividend starts in the quotient register and is shifted out into the remainder
			quotReg    <= req.dividendMag;
			remReg     <= '0;
			divisorReg <= req.divisorMag;
			negQuotReg <= req.negQuot;
			negRemReg  <= req.negRem;
			zeroDivReg <= req.zeroDiv;
		end else if (state == divStDivide) begin
			quotReg <= {quotReg[divWidth-2:0], canSub};
			remReg  <= {remNext, quotReg[divWidth-1]};
		end else if (state == divStResult) begin
			// The final step shifted one spare bit in below the remainder
			quot <= negQuotReg ? -quotReg : quotReg;
			rem  <= negRemReg ? -remReg[divWidth:1] : remReg[divWidth:1];
		end
	end

endmodule

// File: hw/divUnit.sv
// Integer divide unit top level, with operand prep, request queue and restoring core behind plain ports
`timescale 1ns/100ps

module divUnit
	import divPkg::*;
	(
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  logic                abort,
	input  logic                ss,
	input  logic                su,
	input  logic                isDivi,
	input  logic [divWidth-1:0] a,
	input  logic [divWidth-1:0] b,
	input  logic [divWidth-1:0] imm,
	output logic                full,
	output logic                busy,
	output logic                resultValid,
	output logic [divWidth-1:0] quot,
	output logic [divWidth-1:0] rem,
	output logic                dvByZr
);

	// Prepared request on its way into the queue
	divReqIf prepReq ();

	// Oldest queued request, offered to the core
	divReqIf headReq ();

	// Core takes the head entry on this strobe
	logic pop;

	// ============================================================
	// Blocks
	// ============================================================

	divOperandPrep prep0 (
		.issue  (issue),
		.ss     (ss),
		.su     (su),
		.isDivi (isDivi),
		.a      (a),
		.b      (b),
		.imm    (imm),
		.req    (prepReq.src)
	);

	// Abort also flushes everything still waiting
	divReqQueue queue0 (
		.clk    (clk),
		.rst    (rst),
		.flush  (abort),
		.inReq  (prepReq.dst),
		.outReq (headReq.src),
		.pop    (pop),
		.full   (full)
	);

	divRestoringCore core0 (
		.clk         (clk),
		.rst         (rst),
		.abort       (abort),
		.req         (headReq.dst),
		.pop         (pop),
		.busy        (busy),
		.resultValid (resultValid),
		.quot        (quot),
		.rem         (rem),
		.dvByZr      (dvByZr)
	);

endmodule

// File: dv/divUnitChecker.sv
// Testbench checker that watches the divide unit ports and compares each result with a model
`timescale 1ns/100ps

module divUnitChecker
	import divPkg::*;
	(
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  logic                abort,
	input  logic                ss,
	input  logic                su,
	input  logic                isDivi,
	input  logic [divWidth-1:0] a,
	input  logic [divWidth-1:0] b,
	input  logic [divWidth-1:0] imm,
	input  logic                full,
	input  logic                resultValid,
	input  logic [divWidth-1:0] quot,
	input  logic [divWidth-1:0] rem,
	input  logic                dvByZr,
	output int                  errorCount
);

	// One expected answer, with the raw operands kept for the identity check
	typedef struct packed {
		logic [divWidth-1:0] quot;
		logic [divWidth-1:0] rem;
		logic [divWidth-1:0] dividend;
		logic [divWidth-1:0] divisor;
		logic                zeroDiv;
	} expResult;

	// Oldest issue sits at the front, results come back in issue order
	expResult pending [$];

	initial errorCount = 0;

	// ============================================================
	// Reference model
	// ============================================================

	function automatic expResult buildExpected(input logic ssV, input logic suV,
			input logic diviV, input logic [divWidth-1:0] aV,
			input logic [divWidth-1:0] bV, input logic [divWidth-1:0] immV);
		expResult want;
		logic [divWidth-1:0] sel;
		logic [divWidth-1:0] aMag;
		logic [divWidth-1:0] dMag;
		logic [divWidth-1:0] qMag;
		logic [divWidth-1:0] rMag;
		logic negQ;
		logic negR;
		sel = diviV ? immV : bV;
		// Signed mode takes both magnitudes, the mixed mode only the dividend
		aMag = ((ssV || suV) && aV[divWidth-1]) ? (0 - aV) : aV;
		dMag = (ssV && sel[divWidth-1]) ? (0 - sel) : sel;
		negQ = ssV ? (aV[divWidth-1] ^ sel[divWidth-1]) : (suV && aV[divWidth-1]);
		negR = (ssV || suV) && aV[divWidth-1];
		if (dMag == '0) begin
			// Divide by zero gives all ones and hands the dividend back
			qMag = '1;
			rMag = aMag;
		end else begin
			qMag = aMag / dMag;
			rMag = aMag % dMag;
		end
		want.quot     = negQ ? (0 - qMag) : qMag;
		want.rem      = negR ? (0 - rMag) : rMag;
		want.dividend = aV;
		want.divisor  = sel;
		want.zeroDiv  = (sel == '0);
		return want;
	endfunction

	// ============================================================
	// Comparison
	// ============================================================

	task automatic compareResult();
		expResult want;
		logic [divWidth-1:0] rebuilt;
		if (pending.size() == 0) begin
			$display("A result arrived at %0t while no issue was pending", $time);
			errorCount++;
		end else begin
			want = pending.pop_front();
			if (quot !== want.quot) begin
				$display("ERR %0t: quot %h, expected %h", $time, quot, want.quot);
				errorCount++;
			end
			if (rem !== want.rem) begin
				$display("ERR %0t: rem %h, expected %h", $time, rem, want.rem);
				errorCount++;
			end
			if (dvByZr !== want.zeroDiv) begin
				$display("ERR %0t: dvByZr %b, expected %b", $time, dvByZr, want.zeroDiv);
				errorCount++;
			end
			// Quotient times divisor plus remainder wraps back to the dividend in every mode
			rebuilt = quot * want.divisor + rem;
			if (rebuilt !== want.dividend) begin
				$display("ERR %0t: quot*divisor+rem is %h, dividend %h", $time, rebuilt,
					want.dividend);
				errorCount++;
			end
		end
	endtask

	// Inputs change after the edge, so values read here are the ones the DUT sampled
	always @(posedge clk) begin
		if (rst) begin
			pending.delete();
		end else begin
			if (resultValid)
				compareResult();
			// An issue together with abort is dropped by the DUT as well
			if (abort)
				pending.delete();
			else if (issue && !full)
				pending.push_back(buildExpected(ss, su, isDivi, a, b, imm));
		end
	end

endmodule

// File: dv/divUnitTb.sv
// Testbench top for the divide unit, runs LFSR random issues through dut0 and prints the verdict
`timescale 1ns/100ps

module divUnitTb;
	import divPkg::*;

	// Long enough for a full queue plus the running divide
	localparam int resultTimeout = (divWidth + 3) * (divQueueDepth + 2);

	logic                clk;
	logic                rst;
	logic                issue;
	logic                abort;
	logic                ss;
	logic                su;
	logic                isDivi;
	logic [divWidth-1:0] a;
	logic [divWidth-1:0] b;
	logic [divWidth-1:0] imm;
	logic                full;
	logic                busy;
	logic                resultValid;
	logic [divWidth-1:0] quot;
	logic [divWidth-1:0] rem;
	logic                dvByZr;

	logic [31:0] lfsrState;
	int          tbErrors;
	int          timeouts;
	int          checkErrors;

	divUnit dut0 (
		.clk(clk), .rst(rst), .issue(issue), .abort(abort), .ss(ss), .su(su),
		.isDivi(isDivi), .a(a), .b(b), .imm(imm), .full(full), .busy(busy),
		.resultValid(resultValid), .quot(quot), .rem(rem), .dvByZr(dvByZr)
	);

	divUnitChecker check0 (
		.clk(clk), .rst(rst), .issue(issue), .abort(abort), .ss(ss), .su(su),
		.isDivi(isDivi), .a(a), .b(b), .imm(imm), .full(full),
		.resultValid(resultValid), .quot(quot), .rem(rem), .dvByZr(dvByZr),
		.errorCount(checkErrors)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ============================================================
	// Random source
	// ============================================================

	// Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randBits(input int n, output logic [divWidth-1:0] w);
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[divWidth-2:0], lfsrState[0]};
		end
	endtask

	// Positive divisor of random length that is never zero and never above 63 bits
	task automatic randDivisor(output logic [divWidth-1:0] d);
		logic [divWidth-1:0] shift;
		randBits(6, shift);
		randBits(divWidth, d);
		d = d >> (shift[5:0] + 7'd1);
		if (d == '0)
			d = 1;
	endtask

	// ============================================================
	// Stimulus and waits
	// ============================================================

	task automatic driveIssue(input logic ssV, input logic suV, input logic diviV,
			input logic [divWidth-1:0] aV, input logic [divWidth-1:0] bV,
			input logic [divWidth-1:0] immV);
		int waited;
		waited = 0;
		@(posedge clk);
		while (full && waited < resultTimeout) begin
			issue <= 1'b0;
			@(posedge clk);
			waited++;
		end
		if (full) begin
			$display("Timed out waiting for the queue to leave full before an issue");
			timeouts++;
		end
		issue  <= 1'b1;
		ss     <= ssV;
		su     <= suV;
		isDivi <= diviV;
		a      <= aV;
		b      <= bV;
		imm    <= immV;
	endtask

	// Dividend sign and divisor sign are forced and the unused divisor input gets noise
	task automatic issueRandom(input logic ssV, input logic suV, input logic diviV,
			input logic aNeg, input logic dNeg, input logic zeroDiv);
		logic [divWidth-1:0] aV;
		logic [divWidth-1:0] dV;
		logic [divWidth-1:0] noise;
		randBits(divWidth, aV);
		aV[divWidth-1] = aNeg;
		randDivisor(dV);
		if (dNeg)
			dV = 0 - dV;
		if (zeroDiv)
			dV = '0;
		randBits(divWidth, noise);
		noise[0] = 1'b1;
		if (diviV)
			driveIssue(ssV, suV, 1'b1, aV, noise, dV);
		else
			driveIssue(ssV, suV, 1'b0, aV, dV, noise);
	endtask

	// The edge of this call is the sampling edge of the last issue
	task automatic endIssue();
		@(posedge clk);
		issue <= 1'b0;
	endtask

	task automatic waitResults(input int n);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < n && cycles < n * resultTimeout) begin
			@(posedge clk);
			cycles++;
			if (resultValid)
				seen++;
		end
		if (seen < n) begin
			$display("Timed out waiting for %0d results, only %0d arrived", n, seen);
			timeouts++;
		end
	endtask

	task automatic measureLatency();
		int  cycles;
		int  busyCycles;
		logic seen;
		cycles = 0;
		busyCycles = 0;
		seen = 1'b0;
		while (!seen && cycles < resultTimeout) begin
			@(posedge clk);
			cycles++;
			seen = resultValid;
			if (busy)
				busyCycles++;
		end
		// A level read at an edge was set by the edge before
		if (!seen) begin
			$display("Timed out waiting for the result of a lone issue");
			timeouts++;
		end else begin
			if (cycles - 1 != divWidth + 3) begin
				$display("ERR %0t: lone issue latency %0d, expected %0d", $time, cycles - 1,
					divWidth + 3);
				tbErrors++;
			end
			// The divide and result states together last divWidth+2 cycles
			if (busyCycles != divWidth + 2) begin
				$display("ERR %0t: busy high for %0d cycles, expected %0d", $time,
					busyCycles, divWidth + 2);
				tbErrors++;
			end
		end
	endtask

	// Nothing may come out of the unit after an abort
	task automatic checkQuiet(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			if (resultValid || busy || full) begin
				$display("ERR %0t: activity after abort, valid %b busy %b full %b", $time,
					resultValid, busy, full);
				tbErrors++;
			end
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [divWidth-1:0] pick;
		logic [divWidth-1:0] groupSize;
		rst = 1'b1;
		issue = 1'b0;
		abort = 1'b0;
		ss = 1'b0;
		su = 1'b0;
		isDivi = 1'b0;
		a = '0;
		b = '0;
		imm = '0;
		lfsrState = 32'hc763;
		tbErrors = 0;
		timeouts = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		if (resultValid || busy || full || dvByZr) begin
			$display("ERR %0t: outputs not low after reset", $time);
			tbErrors++;
		end

		// Unsigned groups of one to four issues use register and immediate divisors
		for (int g = 0; g < 6; g++) begin
			randBits(2, groupSize);
			for (int k = 0; k <= groupSize[1:0]; k++) begin
				randBits(3, pick);
				issueRandom(1'b0, 1'b0, pick[0], pick[1], pick[2], 1'b0);
			end
			endIssue();
			waitResults(groupSize[1:0] + 1);
		end

		// Signed divides run one group per sign combination with su random since ss wins
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < 3; k++) begin
				randBits(2, pick);
				issueRandom(1'b1, pick[1], pick[0], c[0], c[1], 1'b0);
			end
			endIssue();
			waitResults(3);
		end

		// Signed by unsigned with negative dividends
		for (int k = 0; k < 4; k++) begin
			randBits(2, pick);
			issueRandom(1'b0, 1'b1, pick[0], 1'b1, pick[1], 1'b0);
		end
		endIssue();
		waitResults(4);

		// A zero divisor goes through b and imm in each mode with both dividend signs
		for (int m = 0; m < 3; m++) begin
			for (int k = 0; k < 4; k++)
				issueRandom(m == 0, m == 1, k[0], k[1], 1'b0, 1'b1);
			endIssue();
			waitResults(4);
		end

		// One issue runs in the core and four wait, so full must be up
		for (int k = 0; k < divQueueDepth + 1; k++) begin
			randBits(3, pick);
			issueRandom(pick[0], pick[1], pick[2], pick[1], pick[0], 1'b0);
		end
		endIssue();
		@(posedge clk);
		if (!full) begin
			$display("ERR %0t: full stayed low with four requests pending", $time);
			tbErrors++;
		end
		waitResults(divQueueDepth + 1);

		issueRandom(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		endIssue();
		measureLatency();

		// Abort in the middle of a divide with three more queued
		for (int k = 0; k < divQueueDepth; k++) begin
			randBits(2, pick);
			issueRandom(pick[0], pick[1], pick[0], pick[1], pick[0], 1'b0);
		end
		endIssue();
		repeat (20) @(posedge clk);
		// The issue that comes with the abort is thrown away
		abort <= 1'b1;
		issue <= 1'b1;
		@(posedge clk);
		abort <= 1'b0;
		issue <= 1'b0;
		checkQuiet(3 * (divWidth + 3));

		// Later issues must still be answered after the abort
		for (int g = 0; g < 2; g++) begin
			for (int k = 0; k < 3; k++) begin
				randBits(5, pick);
				issueRandom(pick[0], pick[1], pick[2], pick[3], pick[4], 1'b0);
			end
			endIssue();
			waitResults(3);
		end

		$display("Done: %0d checker errors, %0d testbench errors, %0d timeouts",
			checkErrors, tbErrors, timeouts);
		if (checkErrors + tbErrors + timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: divUnit.f
hw/divPkg.sv
hw/divReqIf.sv
hw/divOperandPrep.sv
hw/divReqQueue.sv
hw/divRestoringCore.sv
hw/divUnit.sv
dv/divUnitChecker.sv
dv/divUnitTb.sv

// File: Bender.yml
package:
  name: divunit

sources:
  # Shared package and interface first, then the blocks and the top level
  - files:
      - hw/divPkg.sv
      - hw/divReqIf.sv
      - hw/divOperandPrep.sv
      - hw/divReqQueue.sv
      - hw/divRestoringCore.sv
      - hw/divUnit.sv

  # Testbench sources, only pulled in for simulation
  - target: test
    files:
      - dv/divUnitChecker.sv
      - dv/divUnitTb.sv
